// File: hw/clock_pkg.sv
package clock_pkg;

	// ----------------------------------------------------------------------
	// operating modes and set positions
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK	= 2'd0,
		MODE_SET_TIME	= 2'd1,
		MODE_SET_ALARM	= 2'd2
	} mode_t;

	// encoding follows the field order on the display, sec lowest
	typedef enum logic [1:0] {
		POS_SEC	= 2'd0,
		POS_MIN	= 2'd1,
		POS_HR	= 2'd2
	} pos_t;

	// bit order on the button and press buses
	localparam int BTN_MODE		= 0;
	localparam int BTN_POS		= 1;
	localparam int BTN_INC		= 2;
	localparam int BTN_ALARM	= 3;

	// ----------------------------------------------------------------------
	// time fields
	// ----------------------------------------------------------------------
	localparam int FIELD_W = 6;

	localparam logic [FIELD_W-1:0] SEC_MAX	= 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX	= 6'd59;
	localparam logic [FIELD_W-1:0] HR_MAX	= 6'd23;

	// divisors for a 50 MHz clk
	localparam logic [31:0] SEC_DIV_DEF	= 32'd50_000_000;	// 1 Hz
	localparam logic [31:0] SAMPLE_DIV_DEF	= 32'd500_000;		// 100 Hz button sample
	localparam logic [31:0] SCAN_DIV_DEF	= 32'd5_000;		// digit scan
	localparam logic [31:0] BLINK_DIV_DEF	= 32'd12_500_000;	// 2 Hz blink
	localparam logic [31:0] TONE_DIV_DEF	= 32'd12_000;		// half period of high pitch

endpackage

// File: hw/disp_pkg.sv
package disp_pkg;

	// segments {a,b,c,d,e,f,g}, active high
	typedef logic [6:0] seg_t;

	localparam int N_DIGITS		= 6;
	localparam int DIGIT_W		= 4;
	localparam int DIGIT_IDX_W	= 3;	// enough for 0..N_DIGITS-1

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// ----------------------------------------------------------------------
	// decimal digit patterns, index is the digit value
	// ----------------------------------------------------------------------
	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

endpackage

// File: hw/tick_gen.sv
module tick_gen import clock_pkg::*; #(
	parameter logic [31:0] SEC_DIV		= SEC_DIV_DEF,
	parameter logic [31:0] SAMPLE_DIV	= SAMPLE_DIV_DEF,
	parameter logic [31:0] SCAN_DIV		= SCAN_DIV_DEF,
	parameter logic [31:0] BLINK_DIV	= BLINK_DIV_DEF
) (
	input  logic	clk,
	input  logic	rst_n,
	output logic	o_sec_tick,
	output logic	o_sample_tick,
	output logic	o_scan_tick,
	output logic	o_blink_phase
);

	localparam logic [31:0] DIV [4] = '{SEC_DIV, SAMPLE_DIV, SCAN_DIV, BLINK_DIV};

	logic [3:0]	tc;	// terminal counts, same order as DIV

	for (genvar g = 0; g < 4; g++) begin : g_div
		logic [31:0]	cnt;

		assign tc[g] = (cnt == DIV[g] - 32'd1);

		always_ff @(posedge clk or negedge rst_n) begin
			if (rst_n == 1'b0) begin
				cnt <= '0;
			end else if (tc[g]) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 32'd1;
			end
		end
	end

	assign o_sec_tick	= tc[0];
	assign o_sample_tick	= tc[1];
	assign o_scan_tick	= tc[2];

	// blink level, starts in the visible half
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_blink_phase <= 1'b1;
		end else if (tc[3]) begin
			o_blink_phase <= ~o_blink_phase;
		end
	end

endmodule

// File: hw/button_sync.sv
module button_sync (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		i_sample_tick,
	input  logic [3:0]	i_btn,
	output logic [3:0]	o_press
);

	logic [3:0]	stage1;
	logic [3:0]	stage2;
	logic [3:0]	armed;		// last seen fully released
	logic		sample_d;	// stages just updated

	// two samples per button at the slow rate
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			stage1	<= '0;
			stage2	<= '0;
			sample_d <= 1'b0;
		end else begin
			sample_d <= i_sample_tick;
			if (i_sample_tick) begin
				stage1 <= i_btn;
				stage2 <= stage1;
			end
		end
	end

	// release memory, one press per push
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			armed <= '1;
		end else if (sample_d) begin
			armed <= (armed & ~(stage1 & stage2)) | (~stage1 & ~stage2);
		end
	end

	assign o_press = {4{sample_d}} & stage1 & stage2 & armed;

endmodule

// File: hw/mode_ctrl.sv
module mode_ctrl import clock_pkg::*; (
	input  logic		clk,
	input  logic		rst_n,
	input  logic [3:0]	i_press,
	output mode_t		o_mode,
	output pos_t		o_pos,
	output logic		o_alarm_en,
	output logic		o_inc_time,
	output logic		o_inc_alarm
);

	mode_t	mode_nxt;
	pos_t	pos_nxt;

	always_comb begin
		case (o_mode)
			MODE_CLOCK:	mode_nxt = MODE_SET_TIME;
			MODE_SET_TIME:	mode_nxt = MODE_SET_ALARM;
			default:	mode_nxt = MODE_CLOCK;
		endcase
	end

	always_comb begin
		case (o_pos)
			POS_SEC:	pos_nxt = POS_MIN;
			POS_MIN:	pos_nxt = POS_HR;
			default:	pos_nxt = POS_SEC;
		endcase
	end

	// ----------------------------------------------------------------------
	// mode FSM, position and alarm enable
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode		<= MODE_CLOCK;
			o_pos		<= POS_SEC;
			o_alarm_en	<= 1'b0;
		end else begin
			if (i_press[BTN_MODE]) begin
				o_mode <= mode_nxt;
			end
			if (i_press[BTN_POS]) begin
				o_pos <= pos_nxt;
			end
			if (i_press[BTN_ALARM]) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// increment goes to time or alarm, dropped in clock mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_inc_time	<= 1'b0;
			o_inc_alarm	<= 1'b0;
		end else begin
			o_inc_time	<= i_press[BTN_INC] && (o_mode == MODE_SET_TIME);
			o_inc_alarm	<= i_press[BTN_INC] && (o_mode == MODE_SET_ALARM);
		end
	end

endmodule

// File: hw/time_keeper.sv
module time_keeper import clock_pkg::*; (
	input  logic			clk,
	input  logic			rst_n,
	input  logic			i_sec_tick,
	input  mode_t			i_mode,
	input  pos_t			i_pos,
	input  logic			i_inc_time,
	input  logic			i_inc_alarm,
	input  logic			i_alarm_en,
	output logic [FIELD_W-1:0]	o_sec,
	output logic [FIELD_W-1:0]	o_min,
	output logic [FIELD_W-1:0]	o_hr,
	output logic [FIELD_W-1:0]	o_alarm_sec,
	output logic [FIELD_W-1:0]	o_alarm_min,
	output logic [FIELD_W-1:0]	o_alarm_hr,
	output logic			o_alarm_on
);

	logic [FIELD_W-1:0]	sec_nxt;
	logic [FIELD_W-1:0]	min_nxt;
	logic [FIELD_W-1:0]	hr_nxt;
	logic			advance;
	logic			match;

	// add one, wrap past the limit
	function automatic logic [FIELD_W-1:0] bump(
		input logic [FIELD_W-1:0] v,
		input logic [FIELD_W-1:0] lim
	);
		return (v >= lim) ? '0 : v + 1'b1;
	endfunction

	// ----------------------------------------------------------------------
	// carry chain for the running time
	// ----------------------------------------------------------------------
	always_comb begin
		sec_nxt	= bump(o_sec, SEC_MAX);
		min_nxt	= o_min;
		hr_nxt	= o_hr;
		if (o_sec >= SEC_MAX) begin
			min_nxt = bump(o_min, MIN_MAX);
			if (o_min >= MIN_MAX) begin
				hr_nxt = bump(o_hr, HR_MAX);
			end
		end
	end

	assign advance	= i_sec_tick && (i_mode != MODE_SET_TIME);	// frozen while setting
	assign match	= (sec_nxt == o_alarm_sec) && (min_nxt == o_alarm_min) &&
			  (hr_nxt == o_alarm_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_sec	<= '0;
			o_min	<= '0;
			o_hr	<= '0;
		end else if (i_inc_time) begin
			case (i_pos)
				POS_SEC:	o_sec	<= bump(o_sec, SEC_MAX);
				POS_MIN:	o_min	<= bump(o_min, MIN_MAX);
				default:	o_hr	<= bump(o_hr, HR_MAX);
			endcase
		end else if (advance) begin
			o_sec	<= sec_nxt;
			o_min	<= min_nxt;
			o_hr	<= hr_nxt;
		end
	end

	// alarm fields, no carry between them
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_sec	<= '0;
			o_alarm_min	<= '0;
			o_alarm_hr	<= '0;
		end else if (i_inc_alarm) begin
			case (i_pos)
				POS_SEC:	o_alarm_sec	<= bump(o_alarm_sec, SEC_MAX);
				POS_MIN:	o_alarm_min	<= bump(o_alarm_min, MIN_MAX);
				default:	o_alarm_hr	<= bump(o_alarm_hr, HR_MAX);
			endcase
		end
	end

	// match latch, held until the alarm is switched off
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_on <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm_on <= 1'b0;
		end else if (advance && match) begin
			o_alarm_on <= 1'b1;
		end
	end

endmodule

// File: hw/seg_scan.sv
module seg_scan import clock_pkg::*, disp_pkg::*; (
	input  logic			clk,
	input  logic			rst_n,
	input  logic			i_scan_tick,
	input  logic			i_blink_phase,
	input  mode_t			i_mode,
	input  pos_t			i_pos,
	input  logic [FIELD_W-1:0]	i_sec,
	input  logic [FIELD_W-1:0]	i_min,
	input  logic [FIELD_W-1:0]	i_hr,
	input  logic [FIELD_W-1:0]	i_alarm_sec,
	input  logic [FIELD_W-1:0]	i_alarm_min,
	input  logic [FIELD_W-1:0]	i_alarm_hr,
	output seg_t			o_seg,
	output logic [N_DIGITS-1:0]	o_seg_enb
);

	logic [DIGIT_IDX_W-1:0]	idx;		// active digit, 0 is sec ones
	logic [DIGIT_IDX_W-2:0]	field_sel;
	logic			show_alarm;
	logic [FIELD_W-1:0]	field;
	logic [DIGIT_W-1:0]	digit;
	logic			blank;

	// ----------------------------------------------------------------------
	// digit scan
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == DIGIT_IDX_W'(N_DIGITS - 1)) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	assign o_seg_enb = ~(N_DIGITS'(1) << idx);

	// two digits per field
	assign field_sel	= idx[DIGIT_IDX_W-1:1];
	assign show_alarm	= (i_mode == MODE_SET_ALARM);

	always_comb begin
		case (field_sel)
			2'd0:		field = show_alarm ? i_alarm_sec : i_sec;
			2'd1:		field = show_alarm ? i_alarm_min : i_min;
			default:	field = show_alarm ? i_alarm_hr : i_hr;
		endcase
	end

	// odd digit is the tens
	assign digit = idx[0] ? DIGIT_W'(field / FIELD_W'(10)) : DIGIT_W'(field % FIELD_W'(10));

	// selected field blinks in both set modes
	assign blank = (i_mode != MODE_CLOCK) && !i_blink_phase && (field_sel == i_pos);

	always_comb begin
		if (blank || digit > DIGIT_W'(9)) begin
			o_seg = SEG_BLANK;
		end else begin
			o_seg = SEG_DIGIT[digit];
		end
	end

endmodule

// File: hw/alarm_tone.sv
module alarm_tone import clock_pkg::*; #(
	parameter logic [31:0] TONE_DIV = TONE_DIV_DEF
) (
	input  logic	clk,
	input  logic	rst_n,
	input  logic	i_alarm_on,
	input  logic	i_sec_tick,
	output logic	o_buzz
);

	logic [31:0]	cnt;
	logic [31:0]	half_period;
	logic		low_pitch;	// flips each second while sounding

	assign half_period = low_pitch ? (TONE_DIV << 1) : TONE_DIV;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt		<= '0;
			low_pitch	<= 1'b0;
			o_buzz		<= 1'b0;
		end else if (!i_alarm_on) begin
			cnt		<= '0;
			low_pitch	<= 1'b0;
			o_buzz		<= 1'b0;
		end else begin
			if (i_sec_tick) begin
				low_pitch <= ~low_pitch;
			end
			// >= covers a pitch drop mid period
			if (cnt >= half_period - 32'd1) begin
				cnt	<= '0;
				o_buzz	<= ~o_buzz;
			end else begin
				cnt <= cnt + 32'd1;
			end
		end
	end

endmodule

// File: hw/clock_top.sv
module clock_top import clock_pkg::*, disp_pkg::*; #(
	parameter logic [31:0] SEC_DIV		= SEC_DIV_DEF,
	parameter logic [31:0] SAMPLE_DIV	= SAMPLE_DIV_DEF,
	parameter logic [31:0] SCAN_DIV		= SCAN_DIV_DEF,
	parameter logic [31:0] BLINK_DIV	= BLINK_DIV_DEF,
	parameter logic [31:0] TONE_DIV		= TONE_DIV_DEF
) (
	input  logic			clk,
	input  logic			rst_n,
	input  logic			i_btn_mode,
	input  logic			i_btn_pos,
	input  logic			i_btn_inc,
	input  logic			i_btn_alarm,
	output seg_t			o_seg,
	output logic [N_DIGITS-1:0]	o_seg_enb,
	output logic			o_buzz
);

	logic			sec_tick;
	logic			sample_tick;
	logic			scan_tick;
	logic			blink_phase;
	logic [3:0]		press;
	mode_t			mode;
	pos_t			pos;
	logic			alarm_en;
	logic			inc_time;
	logic			inc_alarm;
	logic [FIELD_W-1:0]	sec;
	logic [FIELD_W-1:0]	min;
	logic [FIELD_W-1:0]	hr;
	logic [FIELD_W-1:0]	alarm_sec;
	logic [FIELD_W-1:0]	alarm_min;
	logic [FIELD_W-1:0]	alarm_hr;
	logic			alarm_on;

	tick_gen #(
		.SEC_DIV	(SEC_DIV),
		.SAMPLE_DIV	(SAMPLE_DIV),
		.SCAN_DIV	(SCAN_DIV),
		.BLINK_DIV	(BLINK_DIV)
	) u_tick_gen (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_sec_tick	(sec_tick),
		.o_sample_tick	(sample_tick),
		.o_scan_tick	(scan_tick),
		.o_blink_phase	(blink_phase)
	);

	// bit order matches BTN_* in clock_pkg
	button_sync u_button_sync (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_sample_tick	(sample_tick),
		.i_btn		({i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode}),
		.o_press	(press)
	);

	mode_ctrl u_mode_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_press	(press),
		.o_mode		(mode),
		.o_pos		(pos),
		.o_alarm_en	(alarm_en),
		.o_inc_time	(inc_time),
		.o_inc_alarm	(inc_alarm)
	);

	time_keeper u_time_keeper (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_sec_tick	(sec_tick),
		.i_mode		(mode),
		.i_pos		(pos),
		.i_inc_time	(inc_time),
		.i_inc_alarm	(inc_alarm),
		.i_alarm_en	(alarm_en),
		.o_sec		(sec),
		.o_min		(min),
		.o_hr		(hr),
		.o_alarm_sec	(alarm_sec),
		.o_alarm_min	(alarm_min),
		.o_alarm_hr	(alarm_hr),
		.o_alarm_on	(alarm_on)
	);

	seg_scan u_seg_scan (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_blink_phase	(blink_phase),
		.i_mode		(mode),
		.i_pos		(pos),
		.i_sec		(sec),
		.i_min		(min),
		.i_hr		(hr),
		.i_alarm_sec	(alarm_sec),
		.i_alarm_min	(alarm_min),
		.i_alarm_hr	(alarm_hr),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb)
	);

	alarm_tone #(
		.TONE_DIV	(TONE_DIV)
	) u_alarm_tone (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_alarm_on	(alarm_on),
		.i_sec_tick	(sec_tick),
		.o_buzz		(o_buzz)
	);

endmodule

// File: dv/clock_checker.sv
module clock_checker import clock_pkg::*, disp_pkg::*; (
	input  logic			clk,
	input  logic			rst_n,
	input  seg_t			o_seg,
	input  logic [N_DIGITS-1:0]	o_seg_enb,
	input  logic			o_buzz,
	input  mode_t			mode,
	input  logic			alarm_en
);

	int fail_cnt = 0;	// read by the testbench at the end

	// ----------------------------------------------------------------------
	// digit scan
	// ----------------------------------------------------------------------
	a_one_low: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb))
	else begin
		$error("o_seg_enb does not have exactly one digit enabled");
		fail_cnt++;
	end

	// low bit steps from digit k to k+1, 5 wraps to 0
	a_scan_step: assert property (@(posedge clk) disable iff (!rst_n)
		(o_seg_enb != $past(o_seg_enb)) |->
		(o_seg_enb == $past({o_seg_enb[N_DIGITS-2:0], o_seg_enb[N_DIGITS-1]})))
	else begin
		$error("digit scan skipped or reversed");
		fail_cnt++;
	end

	a_clock_not_blank: assert property (@(posedge clk) disable iff (!rst_n)
		(mode == MODE_CLOCK) |-> (o_seg != SEG_BLANK))
	else begin
		$error("digit blanked in clock mode");
		fail_cnt++;
	end

	// alarm off, tone gone two cycles later
	a_buzz_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!alarm_en |-> ##2 !o_buzz)
	else begin
		$error("o_buzz active with the alarm disabled");
		fail_cnt++;
	end

endmodule

bind clock_top clock_checker chk_i (
	.clk		(clk),
	.rst_n		(rst_n),
	.o_seg		(o_seg),
	.o_seg_enb	(o_seg_enb),
	.o_buzz		(o_buzz),
	.mode		(mode),
	.alarm_en	(alarm_en)
);

// File: dv/clock_tb.sv
module clock_tb import clock_pkg::*, disp_pkg::*;;

	localparam int SEC_DIV		= 200;
	localparam int PRESS_CYC	= 160;	// worst case incl. alignment
	localparam longint WATCHDOG	= (220 * PRESS_CYC + 70 * SEC_DIV + 8) * 20 * 11 / 10;

	localparam seg_t PATTERN [10] = '{7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
		7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1110011};

	logic		clk = 1'b0;
	logic		rst_n;
	logic [3:0]	btn;
	seg_t		o_seg;
	logic [5:0]	o_seg_enb;
	logic		o_buzz;

	// reference model
	int		cyc;
	mode_t		ref_mode;
	pos_t		ref_pos;
	logic [5:0]	ref_t [3];	// sec, min, hr
	logic [5:0]	ref_a [3];
	logic		ref_en;
	logic		ref_alarm;
	logic		rolled;
	logic		req_go;
	int		req_btn;
	logic		busy;
	logic [5:0]	seen_blank;	// one bit per digit
	int		errors;
	int		n;
	int		k;

	clock_top #(
		.SEC_DIV	(SEC_DIV),
		.SAMPLE_DIV	(4),
		.SCAN_DIV	(3),
		.BLINK_DIV	(50),
		.TONE_DIV	(5)
	) dut_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(btn[BTN_MODE]),
		.i_btn_pos	(btn[BTN_POS]),
		.i_btn_inc	(btn[BTN_INC]),
		.i_btn_alarm	(btn[BTN_ALARM]),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb),
		.o_buzz		(o_buzz)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic logic [5:0] wrap_inc(input logic [5:0] v, input int lim);
		return (v >= lim) ? 6'd0 : v + 6'd1;
	endfunction

	function automatic int field_lim(input int f);
		return (f == 2) ? 23 : 59;
	endfunction

	// ----------------------------------------------------------------------
	// reference time, one second every SEC_DIV cycles from reset
	// ----------------------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc <= 0;
			ref_mode <= MODE_CLOCK;
			ref_pos <= POS_SEC;
			ref_t <= '{6'd0, 6'd0, 6'd0};
			ref_a <= '{6'd0, 6'd0, 6'd0};
			ref_en <= 1'b0;
			ref_alarm <= 1'b0;
			rolled <= 1'b0;
		end else begin
			cyc <= (cyc == SEC_DIV - 1) ? 0 : cyc + 1;
			if (req_go) begin
				case (req_btn)
					BTN_MODE: ref_mode <= (ref_mode == MODE_CLOCK) ? MODE_SET_TIME :
						(ref_mode == MODE_SET_TIME) ? MODE_SET_ALARM : MODE_CLOCK;
					BTN_POS: ref_pos <= (ref_pos == POS_SEC) ? POS_MIN :
						(ref_pos == POS_MIN) ? POS_HR : POS_SEC;
					BTN_INC: begin
						if (ref_mode == MODE_SET_TIME)
							ref_t[ref_pos] <= wrap_inc(ref_t[ref_pos], field_lim(ref_pos));
						if (ref_mode == MODE_SET_ALARM)
							ref_a[ref_pos] <= wrap_inc(ref_a[ref_pos], field_lim(ref_pos));
					end
					default: begin
						ref_en <= !ref_en;
						if (ref_en) ref_alarm <= 1'b0;
					end
				endcase
			end else if (cyc == SEC_DIV - 1 && ref_mode != MODE_SET_TIME) begin
				automatic logic [5:0] s = wrap_inc(ref_t[0], 59);
				automatic logic [5:0] m = (ref_t[0] == 59) ? wrap_inc(ref_t[1], 59) : ref_t[1];
				automatic logic [5:0] h = (ref_t[0] == 59 && ref_t[1] == 59) ?
					wrap_inc(ref_t[2], 23) : ref_t[2];
				ref_t <= '{s, m, h};
				if (s == 0 && m == 0 && h == 0) rolled <= 1'b1;
				if (ref_en && s == ref_a[0] && m == ref_a[1] && h == ref_a[2])
					ref_alarm <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// display and tone compared on the falling edge
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n && !busy) begin
			for (int i = 0; i < 6; i++) begin
				if (!o_seg_enb[i]) begin
					automatic logic [5:0] v = (ref_mode == MODE_SET_ALARM) ?
						ref_a[i / 2] : ref_t[i / 2];
					automatic seg_t exp_seg = PATTERN[(i % 2) ? v / 10 : v % 10];
					if (ref_mode != MODE_CLOCK && o_seg == SEG_BLANK && i / 2 == ref_pos) begin
						seen_blank[i] = 1'b1;
					end else begin
						assert (o_seg == exp_seg) else begin
							$display("** Error at %0t: o_seg (digit %0d) = %b, expected %b",
								$time, i, o_seg, exp_seg);
							errors++;
						end
					end
				end
			end
		end
		if (rst_n && !ref_alarm) begin
			assert (o_buzz == 1'b0) else begin
				$display("** Error at %0t: o_buzz = %b, expected 0", $time, o_buzz);
				errors++;
			end
		end
	end

	// one press, started clear of a second boundary
	task automatic press(input int b);
		repeat ($urandom_range(7, 0)) @(posedge clk);
		@(negedge clk);
		while (cyc > 150 || cyc < 2) @(negedge clk);
		@(posedge clk);
		busy = 1'b1;
		btn[b] <= 1'b1;
		repeat (20) @(posedge clk);
		req_btn <= b;
		req_go <= 1'b1;
		@(posedge clk);
		req_go <= 1'b0;
		busy = 1'b0;
		repeat (27) @(posedge clk);
		btn[b] <= 1'b0;
		repeat (48) @(posedge clk);
	endtask

	task automatic press_n(input int b, input int cnt);
		repeat (cnt) press(b);
	endtask

	task automatic wait_secs(input int s);
		repeat (s * SEC_DIV) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'h252129c6));
		rst_n = 1'b0;
		btn = '0;
		req_go = 1'b0;
		req_btn = 0;
		busy = 1'b0;
		seen_blank = '0;
		errors = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		wait_secs(3);

		// set time to 23:59:50, hours wrapped once on the way
		press(BTN_MODE);
		wait_secs(2);
		press_n(BTN_INC, (50 - ref_t[0] + 60) % 60);
		press(BTN_POS);
		press_n(BTN_INC, 59);
		press(BTN_POS);
		press_n(BTN_INC, 47);
		assert (&seen_blank) else begin
			$display("a digit of the selected field was never blanked in set mode");
			errors++;
		end
		press_n(BTN_MODE, 2);
		wait_secs(14);
		assert (rolled) else begin
			$display("time never rolled over from 23:59:59");
			errors++;
		end

		// alarm a few seconds ahead, then enabled
		press_n(BTN_MODE, 2);
		press(BTN_POS);
		k = 2 * ref_t[0] + 10;
		press_n(BTN_INC, k);
		press(BTN_MODE);
		press(BTN_ALARM);
		n = 0;
		while (!ref_alarm && n < 20 * SEC_DIV) begin
			@(negedge clk);
			n++;
		end
		n = 0;
		while (!o_buzz && n < 3 * SEC_DIV) begin
			@(negedge clk);
			n++;
		end
		assert (ref_alarm && o_buzz) else begin
			$display("alarm did not sound within 3 seconds of the alarm time");
			errors++;
		end
		wait_secs(1);
		press(BTN_ALARM);
		wait_secs(2);

		// disabled alarm passes its time silently
		press_n(BTN_MODE, 2);
		press_n(BTN_INC, 20);
		press(BTN_MODE);
		wait_secs(10);

		$display("errors: %0d testbench, %0d assertion", errors, dut_i.chk_i.fail_cnt);
		if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired, run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: files.f
hw/clock_pkg.sv
hw/disp_pkg.sv
hw/tick_gen.sv
hw/button_sync.sv
hw/mode_ctrl.sv
hw/time_keeper.sv
hw/seg_scan.sv
hw/alarm_tone.sv
hw/clock_top.sv
dv/clock_checker.sv
dv/clock_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module clock_tb -f files.f -o clock_sim

./obj_dir/clock_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^>>> PASS$" sim.log
